//--- compile.f
hdl/prf_pkg.sv
hdl/prf_read_arbiter.sv
hdl/prf_wb_arbiter.sv
hdl/prf_bank.sv
hdl/prf.sv
dv/prf_assert.sv
dv/prf_tb.sv

//--- dv/prf_assert.sv
// concurrent checks on the read and writeback arbiters
// bound once to each arbiter from the testbench
// the side that the arbiter does not own is tied to zero

`timescale 1ns/10ps

module prf_assert (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  prf_pkg::pr_t [prf_pkg::PRF_RR_COUNT-1:0]        req_pr,
    input  prf_pkg::rr_mask_t                               rd_ack,
    input  prf_pkg::rr_mask_t                               rd_port,
    input  prf_pkg::wb_req_t [prf_pkg::PRF_WR_COUNT-1:0]    wb_req,
    input  prf_pkg::wr_mask_t                               wb_ready
);
    import prf_pkg::*;

    rr_mask_t [PRF_BANK_COUNT-1:0]  ack_in_bank;
    wr_mask_t [PRF_BANK_COUNT-1:0]  ready_in_bank;
    wr_mask_t                       wb_valid;

    // sort grants by the bank of the request they serve
    always_comb begin
        for (int wr = 0; wr < PRF_WR_COUNT; wr++) begin
            wb_valid[wr] = wb_req[wr].valid;
        end
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
                ack_in_bank[b][rr] = rd_ack[rr] &&
                    (req_pr[rr][LOG_PRF_BANK_COUNT-1:0] == LOG_PRF_BANK_COUNT'(b));
            end
            for (int wr = 0; wr < PRF_WR_COUNT; wr++) begin
                ready_in_bank[b][wr] = wb_ready[wr] &&
                    (wb_req[wr].pr[LOG_PRF_BANK_COUNT-1:0] == LOG_PRF_BANK_COUNT'(b));
            end
        end
    end

    a_port_needs_ack: assert property (@(posedge CLK) disable iff (!nRST)
        (rd_port & ~rd_ack) == '0)
        else $error("rd_port set without rd_ack");

    a_ready_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
        (wb_ready & ~wb_valid) == '0)
        else $error("wb_ready set without wb_req valid");

    // ------------------------------------------------------------------
    // per bank port limits
    // ------------------------------------------------------------------
    for (genvar b = 0; b < PRF_BANK_COUNT; b++) begin : g_bank
        a_two_reads: assert property (@(posedge CLK) disable iff (!nRST)
            $countones(ack_in_bank[b]) <= 2)
            else $error("more than two read acknowledges on bank %0d", b);

        a_one_write: assert property (@(posedge CLK) disable iff (!nRST)
            $onehot0(ready_in_bank[b]))
            else $error("more than one writeback ready on bank %0d", b);
    end

endmodule

//--- dv/prf_tb.sv
// testbench for the banked physical register file
// random reads and writebacks from a fixed seed, with phases that aim
// every request at one bank. a model of the array and of the pending
// requests checks acknowledges and predicts read data and the wakeup bus.

`timescale 1ns/10ps

module prf_tb;
    import prf_pkg::*;

    localparam int RUN_CYCLES    = 3000;
    localparam int DRAIN_TIMEOUT = 16;

    logic                               CLK;
    logic                               nRST;
    rd_req_t [PRF_RR_COUNT-1:0]         rd_req;
    rr_mask_t                           rd_ack;
    rr_mask_t                           rd_port;
    word_t [PRF_BANK_COUNT-1:0][1:0]    rd_data;
    wb_req_t [PRF_WR_COUNT-1:0]         wb_req;
    wr_mask_t                           wb_ready;
    wb_bus_t [PRF_BANK_COUNT-1:0]       wb_bus;

    integer                             seed;
    int                                 drain_cycles;

    // model of the array and of the requesters
    word_t                              model_mem [PR_COUNT];
    rr_mask_t                           rd_pending;
    pr_t                                rd_pend_pr [PRF_RR_COUNT];
    int                                 rd_age [PRF_RR_COUNT];
    wr_mask_t                           wb_hold;
    wb_req_t                            wb_hold_req [PRF_WR_COUNT];
    int                                 wb_age [PRF_WR_COUNT];

    // expected outputs for the next cycle
    logic [PRF_BANK_COUNT-1:0][1:0]     exp_rd_valid;
    word_t [PRF_BANK_COUNT-1:0][1:0]    exp_rd_word;
    wb_bus_t [PRF_BANK_COUNT-1:0]       exp_wb;

    // bank conflict phase
    int                                 hot_left;
    logic [LOG_PRF_BANK_COUNT-1:0]      hot_bank;

    prf i_prf (
        .CLK      (CLK),
        .nRST     (nRST),
        .rd_req   (rd_req),
        .rd_ack   (rd_ack),
        .rd_port  (rd_port),
        .rd_data  (rd_data),
        .wb_req   (wb_req),
        .wb_ready (wb_ready),
        .wb_bus   (wb_bus)
    );

    bind prf_read_arbiter prf_assert i_read_assert (
        .CLK       (CLK),
        .nRST      (nRST),
        .req_pr    (req_pr),
        .rd_ack    (rd_ack),
        .rd_port   (rd_port),
        .wb_req    ('0),
        .wb_ready  ('0)
    );

    bind prf_wb_arbiter prf_assert i_wb_assert (
        .CLK       (CLK),
        .nRST      (nRST),
        .req_pr    ('0),
        .rd_ack    ('0),
        .rd_port   ('0),
        .wb_req    (wb_req),
        .wb_ready  (wb_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // ------------------------------------------------------------------
    // error reporting and compare tasks
    // ------------------------------------------------------------------
    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_wb_bus(input string name, input wb_bus_t actual,
                                input wb_bus_t expected);
        // upper_pr only matters while valid
        if ((actual.valid !== expected.valid) ||
            (expected.valid && (actual.upper_pr !== expected.upper_pr))) begin
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_mask(input string name, input rr_mask_t actual,
                              input rr_mask_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s = %b, expected %b",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_wr_mask(input string name, input wr_mask_t actual,
                                 input wr_mask_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s = %b, expected %b",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    function automatic pr_t random_pr();
        pr_t pr;
        pr = pr_t'($random(seed));
        if (hot_left > 0) begin
            pr[LOG_PRF_BANK_COUNT-1:0] = hot_bank;
        end
        return pr;
    endfunction

    // called right after a rising edge
    // new strobes only for idle requesters
    task automatic drive_inputs(input bit allow_new);
        rd_req_t rq;
        if (hot_left > 0) begin
            hot_left--;
        end else if (allow_new && (($random(seed) & 15) == 0)) begin
            hot_left = 6 + ($random(seed) & 7);
            hot_bank = LOG_PRF_BANK_COUNT'($random(seed));
        end
        for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
            rq = '0;
            if (allow_new && !rd_pending[rr] && (($random(seed) & 3) != 0)) begin
                rq.valid       = 1'b1;
                rq.pr          = random_pr();
                rd_pending[rr] = 1'b1;
                rd_pend_pr[rr] = rq.pr;
                rd_age[rr]     = 0;
            end
            rd_req[rr] <= rq;
        end
        for (int wr = 0; wr < PRF_WR_COUNT; wr++) begin
            if (allow_new && !wb_hold[wr] && (($random(seed) & 3) != 0)) begin
                wb_hold_req[wr].valid = 1'b1;
                wb_hold_req[wr].data  = word_t'($random(seed));
                wb_hold_req[wr].pr    = random_pr();
                wb_hold[wr]           = 1'b1;
                wb_age[wr]            = 0;
            end
            wb_req[wr] <= wb_hold[wr] ? wb_hold_req[wr] : '0;
        end
    endtask

    // ------------------------------------------------------------------
    // per cycle scoring at the falling edge
    // ------------------------------------------------------------------
    task automatic score_cycle();
        int  b;
        int  p;
        pr_t pr;
        // outputs predicted in the previous cycle
        for (b = 0; b < PRF_BANK_COUNT; b++) begin
            for (p = 0; p < 2; p++) begin
                if (exp_rd_valid[b][p]) begin
                    check_word($sformatf("rd_data[%0d][%0d]", b, p),
                               rd_data[b][p], exp_rd_word[b][p]);
                end
            end
            check_wb_bus($sformatf("wb_bus[%0d]", b), wb_bus[b], exp_wb[b]);
        end

        // writebacks commit first so reads of this cycle see them
        check_wr_mask("wb_ready", wb_ready, wb_ready & wb_hold);
        exp_wb = '0;
        for (int wr = 0; wr < PRF_WR_COUNT; wr++) begin
            pr = wb_hold_req[wr].pr;
            b  = int'(pr[LOG_PRF_BANK_COUNT-1:0]);
            if (wb_ready[wr]) begin
                if (exp_wb[b].valid) begin
                    report_error($sformatf("two writebacks accepted on bank %0d", b));
                end
                exp_wb[b].valid    = 1'b1;
                exp_wb[b].upper_pr = pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
                model_mem[pr]      = wb_hold_req[wr].data;
                wb_hold[wr]        = 1'b0;
            end else if (wb_hold[wr]) begin
                wb_age[wr]++;
                if (wb_age[wr] >= PRF_WR_COUNT) begin
                    report_error($sformatf("writeback %0d not accepted in time", wr));
                end
            end
        end

        check_mask("rd_ack", rd_ack, rd_ack & rd_pending);
        check_mask("rd_port", rd_port, rd_port & rd_ack);
        exp_rd_valid = '0;
        for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
            pr = rd_pend_pr[rr];
            b  = int'(pr[LOG_PRF_BANK_COUNT-1:0]);
            p  = int'(rd_port[rr]);
            if (rd_ack[rr]) begin
                if (exp_rd_valid[b][p]) begin
                    report_error($sformatf("two reads served on bank %0d port %0d", b, p));
                end
                exp_rd_valid[b][p] = 1'b1;
                exp_rd_word[b][p]  = model_mem[pr];
                rd_pending[rr]     = 1'b0;
            end else if (rd_pending[rr]) begin
                rd_age[rr]++;
                if (rd_age[rr] >= PRF_RR_COUNT) begin
                    report_error($sformatf("read %0d not acknowledged in time", rr));
                end
            end
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        seed         = 71;
        nRST         = 1'b0;
        rd_req       = '0;
        wb_req       = '0;
        rd_pending   = '0;
        wb_hold      = '0;
        exp_rd_valid = '0;
        exp_rd_word  = '0;
        exp_wb       = '0;
        hot_left     = 0;
        hot_bank     = '0;
        for (int i = 0; i < PR_COUNT; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < PRF_WR_COUNT; i++) begin
            wb_hold_req[i] = '0;
        end

        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_mask("rd_ack", rd_ack, '0);
        check_mask("rd_port", rd_port, '0);
        check_wr_mask("wb_ready", wb_ready, '0);
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            check_wb_bus($sformatf("wb_bus[%0d]", b), wb_bus[b], '0);
        end

        for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
            @(posedge CLK);
            drive_inputs(1'b1);
            @(negedge CLK);
            score_cycle();
        end

        // let held requests finish and score the last outputs
        drain_cycles = 0;
        while ((rd_pending != '0) || (wb_hold != '0)) begin
            @(posedge CLK);
            drive_inputs(1'b0);
            @(negedge CLK);
            score_cycle();
            drain_cycles++;
            if (drain_cycles > DRAIN_TIMEOUT) begin
                report_error("requests still outstanding after the drain timeout");
            end
        end
        @(posedge CLK);
        drive_inputs(1'b0);
        @(negedge CLK);
        score_cycle();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- hdl/prf.sv
// top level of the banked physical register file
// read requesters strobe a pr and get an acknowledge naming the port, then
// the data one cycle later on that bank and port. writeback requesters
// hold their request until ready, and each accepted write shows up on the
// bank's writeback bus in the next cycle for wakeup.

`timescale 1ns/10ps

module prf (
    input  logic                                                    CLK,
    input  logic                                                    nRST,

    // read side
    input  prf_pkg::rd_req_t [prf_pkg::PRF_RR_COUNT-1:0]            rd_req,
    output prf_pkg::rr_mask_t                                       rd_ack,
    output prf_pkg::rr_mask_t                                       rd_port,
    output prf_pkg::word_t [prf_pkg::PRF_BANK_COUNT-1:0][1:0]       rd_data,

    // writeback side
    input  prf_pkg::wb_req_t [prf_pkg::PRF_WR_COUNT-1:0]            wb_req,
    output prf_pkg::wr_mask_t                                       wb_ready,
    output prf_pkg::wb_bus_t [prf_pkg::PRF_BANK_COUNT-1:0]          wb_bus
);
    import prf_pkg::*;

    bank_rd_sel_t [PRF_BANK_COUNT-1:0]  bank_rd_sel;
    bank_wr_t [PRF_BANK_COUNT-1:0]      bank_wr;

    // ------------------------------------------------------------------
    // arbiters
    // ------------------------------------------------------------------
    prf_read_arbiter i_read_arbiter (
        .CLK         (CLK),
        .nRST        (nRST),
        .rd_req      (rd_req),
        .rd_ack      (rd_ack),
        .rd_port     (rd_port),
        .bank_rd_sel (bank_rd_sel)
    );

    prf_wb_arbiter i_wb_arbiter (
        .CLK      (CLK),
        .nRST     (nRST),
        .wb_req   (wb_req),
        .wb_ready (wb_ready),
        .bank_wr  (bank_wr)
    );

    // ------------------------------------------------------------------
    // banks
    // ------------------------------------------------------------------
    for (genvar b = 0; b < PRF_BANK_COUNT; b++) begin : g_bank
        prf_bank i_bank (
            .CLK     (CLK),
            .nRST    (nRST),
            .rd_sel  (bank_rd_sel[b]),
            .wr      (bank_wr[b]),
            .rd_data (rd_data[b]),
            .wb_bus  (wb_bus[b])
        );
    end

endmodule

//--- hdl/prf_bank.sv
// storage for one bank of the register file
// two read ports with registered indices, so data follows the acknowledge
// by one cycle. one write port, committed at the end of the cycle, and the
// written upper PR is broadcast on the writeback bus one cycle later.

`timescale 1ns/10ps

module prf_bank (
    input  logic                    CLK,
    input  logic                    nRST,
    input  prf_pkg::bank_rd_sel_t   rd_sel,
    input  prf_pkg::bank_wr_t       wr,
    output prf_pkg::word_t [1:0]    rd_data,
    output prf_pkg::wb_bus_t        wb_bus
);
    import prf_pkg::*;

    word_t          mem [BANK_DEPTH];
    bank_rd_sel_t   rd_sel_q;

    // ------------------------------------------------------------------
    // array write
    // ------------------------------------------------------------------
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.valid) begin
            mem[wr.upper_pr] <= wr.data;
        end
    end

    // ------------------------------------------------------------------
    // read indices and wakeup bus
    // ------------------------------------------------------------------
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_sel_q <= '0;
            wb_bus   <= '0;
        end else begin
            rd_sel_q        <= rd_sel;
            wb_bus.valid    <= wr.valid;
            wb_bus.upper_pr <= wr.upper_pr;
        end
    end

    // array read after the index register, sees this cycle's committed write
    assign rd_data[0] = mem[rd_sel_q.port0_upper_pr];
    assign rd_data[1] = mem[rd_sel_q.port1_upper_pr];

endmodule

//--- hdl/prf_pkg.sv
// shared sizes, vector types and structs for the banked physical register file
// every module of the register file and the testbench import from here

package prf_pkg;

    // ------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------
    localparam int PR_COUNT           = 64;
    localparam int LOG_PR_COUNT       = 6;
    localparam int PRF_BANK_COUNT     = 4;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int PRF_RR_COUNT       = 4;
    localparam int PRF_WR_COUNT       = 3;

    // entries per bank, addressed by the upper PR
    localparam int BANK_DEPTH     = PR_COUNT / PRF_BANK_COUNT;
    localparam int LOG_BANK_DEPTH = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;

    // ------------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------------
    typedef logic [31:0]                word_t;
    typedef logic [LOG_PR_COUNT-1:0]    pr_t;
    typedef logic [LOG_BANK_DEPTH-1:0]  upper_pr_t;
    typedef logic [PRF_RR_COUNT-1:0]    rr_mask_t;
    typedef logic [PRF_WR_COUNT-1:0]    wr_mask_t;

    // ------------------------------------------------------------------
    // request and bus structs
    // ------------------------------------------------------------------
    // read strobe from one requester, bank in the low pr bits
    typedef struct packed {
        logic   valid;
        pr_t    pr;
    } rd_req_t;

    // writeback held by its requester until ready
    typedef struct packed {
        logic   valid;
        word_t  data;
        pr_t    pr;
    } wb_req_t;

    // indices granted to the two read ports of one bank
    typedef struct packed {
        upper_pr_t  port0_upper_pr;
        upper_pr_t  port1_upper_pr;
    } bank_rd_sel_t;

    // the single write of one bank per cycle
    typedef struct packed {
        logic       valid;
        upper_pr_t  upper_pr;
        word_t      data;
    } bank_wr_t;

    // wakeup broadcast, one per bank
    typedef struct packed {
        logic       valid;
        upper_pr_t  upper_pr;
    } wb_bus_t;

endpackage

//--- hdl/prf_read_arbiter.sv
// read arbitration for the banked register file
// merges new read strobes with held ones, sorts them to banks by the low
// pr bits and grants up to two requesters per bank, round-robin with the
// higher index first. losers are held here until acknowledged.

`timescale 1ns/10ps

module prf_read_arbiter (
    input  logic                                                CLK,
    input  logic                                                nRST,
    input  prf_pkg::rd_req_t [prf_pkg::PRF_RR_COUNT-1:0]        rd_req,
    output prf_pkg::rr_mask_t                                   rd_ack,
    output prf_pkg::rr_mask_t                                   rd_port,
    output prf_pkg::bank_rd_sel_t [prf_pkg::PRF_BANK_COUNT-1:0] bank_rd_sel
);
    import prf_pkg::*;

    // held requests, waiting for an acknowledge
    rr_mask_t                       held_valid;
    pr_t [PRF_RR_COUNT-1:0]         held_pr;

    // new strobes merged with the held ones
    rr_mask_t                       req_valid;
    pr_t [PRF_RR_COUNT-1:0]         req_pr;

    rr_mask_t [PRF_BANK_COUNT-1:0]  bank_req;
    rr_mask_t [PRF_BANK_COUNT-1:0]  port0_ack;
    rr_mask_t [PRF_BANK_COUNT-1:0]  port1_ack;

    // round-robin priority, requesters below the last served ones
    rr_mask_t [PRF_BANK_COUNT-1:0]  prio_mask;
    rr_mask_t [PRF_BANK_COUNT-1:0]  next_prio_mask;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    // one-hot of the highest set bit
    function automatic rr_mask_t pick_high(input rr_mask_t vec);
        rr_mask_t onehot;
        onehot = '0;
        for (int i = 0; i < PRF_RR_COUNT; i++) begin
            if (vec[i]) begin
                onehot    = '0;
                onehot[i] = 1'b1;
            end
        end
        return onehot;
    endfunction

    // masked requesters first, else everyone
    function automatic rr_mask_t grant(input rr_mask_t req, input rr_mask_t mask);
        if (|(req & mask)) begin
            return pick_high(req & mask);
        end
        return pick_high(req);
    endfunction

    // bits strictly below the lowest acknowledged requester
    function automatic rr_mask_t below_lowest(input rr_mask_t ack);
        rr_mask_t mask;
        logic     below;
        below = 1'b1;
        for (int i = 0; i < PRF_RR_COUNT; i++) begin
            if (ack[i]) begin
                below = 1'b0;
            end
            mask[i] = below;
        end
        return mask;
    endfunction

    // ------------------------------------------------------------------
    // merge and arbitrate
    // ------------------------------------------------------------------
    always_comb begin
        for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
            req_valid[rr] = rd_req[rr].valid | held_valid[rr];
            req_pr[rr]    = held_valid[rr] ? held_pr[rr] : rd_req[rr].pr;
        end
    end

    always_comb begin
        rd_ack  = '0;
        rd_port = '0;
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
                bank_req[b][rr] = req_valid[rr] &&
                    (req_pr[rr][LOG_PRF_BANK_COUNT-1:0] == LOG_PRF_BANK_COUNT'(b));
            end
            // port 1 takes the best of what port 0 left
            port0_ack[b] = grant(bank_req[b], prio_mask[b]);
            port1_ack[b] = grant(bank_req[b] & ~port0_ack[b], prio_mask[b]);

            rd_ack  |= port0_ack[b] | port1_ack[b];
            rd_port |= port1_ack[b];

            // idle bank keeps its priority
            if (|(port0_ack[b] | port1_ack[b])) begin
                next_prio_mask[b] = below_lowest(port0_ack[b] | port1_ack[b]);
            end else begin
                next_prio_mask[b] = prio_mask[b];
            end
        end
    end

    // one-hot mux of the granted upper PRs
    always_comb begin
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            bank_rd_sel[b] = '0;
            for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
                if (port0_ack[b][rr]) begin
                    bank_rd_sel[b].port0_upper_pr = req_pr[rr][LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
                end
                if (port1_ack[b][rr]) begin
                    bank_rd_sel[b].port1_upper_pr = req_pr[rr][LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // state
    // ------------------------------------------------------------------
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
            prio_mask  <= '0;
        end else begin
            held_valid <= req_valid & ~rd_ack;
            prio_mask  <= next_prio_mask;
        end
    end

    always_ff @(posedge CLK) begin
        held_pr <= req_pr;
    end

endmodule

//--- hdl/prf_wb_arbiter.sv
// writeback arbitration for the banked register file
// each bank takes at most one writeback per cycle, chosen round-robin with
// the higher index first. ready is combinational and the requester holds
// its writeback until it sees ready.

`timescale 1ns/10ps

module prf_wb_arbiter (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  prf_pkg::wb_req_t [prf_pkg::PRF_WR_COUNT-1:0]    wb_req,
    output prf_pkg::wr_mask_t                               wb_ready,
    output prf_pkg::bank_wr_t [prf_pkg::PRF_BANK_COUNT-1:0] bank_wr
);
    import prf_pkg::*;

    wr_mask_t [PRF_BANK_COUNT-1:0]  bank_req;
    wr_mask_t [PRF_BANK_COUNT-1:0]  wr_grant;

    // round-robin priority per bank
    wr_mask_t [PRF_BANK_COUNT-1:0]  prio_mask;
    wr_mask_t [PRF_BANK_COUNT-1:0]  next_prio_mask;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    // one-hot of the highest set bit
    function automatic wr_mask_t pick_high(input wr_mask_t vec);
        wr_mask_t onehot;
        onehot = '0;
        for (int i = 0; i < PRF_WR_COUNT; i++) begin
            if (vec[i]) begin
                onehot    = '0;
                onehot[i] = 1'b1;
            end
        end
        return onehot;
    endfunction

    function automatic wr_mask_t grant(input wr_mask_t req, input wr_mask_t mask);
        if (|(req & mask)) begin
            return pick_high(req & mask);
        end
        return pick_high(req);
    endfunction

    // bits below the granted writer
    function automatic wr_mask_t below_lowest(input wr_mask_t ack);
        wr_mask_t mask;
        logic     below;
        below = 1'b1;
        for (int i = 0; i < PRF_WR_COUNT; i++) begin
            if (ack[i]) begin
                below = 1'b0;
            end
            mask[i] = below;
        end
        return mask;
    endfunction

    // ------------------------------------------------------------------
    // arbitrate and forward to the banks
    // ------------------------------------------------------------------
    always_comb begin
        wb_ready = '0;
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            for (int wr = 0; wr < PRF_WR_COUNT; wr++) begin
                bank_req[b][wr] = wb_req[wr].valid &&
                    (wb_req[wr].pr[LOG_PRF_BANK_COUNT-1:0] == LOG_PRF_BANK_COUNT'(b));
            end
            wr_grant[b] = grant(bank_req[b], prio_mask[b]);
            wb_ready   |= wr_grant[b];

            bank_wr[b] = '0;
            for (int wr = 0; wr < PRF_WR_COUNT; wr++) begin
                if (wr_grant[b][wr]) begin
                    bank_wr[b].valid    = 1'b1;
                    bank_wr[b].upper_pr = wb_req[wr].pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
                    bank_wr[b].data     = wb_req[wr].data;
                end
            end

            if (|wr_grant[b]) begin
                next_prio_mask[b] = below_lowest(wr_grant[b]);
            end else begin
                next_prio_mask[b] = prio_mask[b];
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            prio_mask <= '0;
        end else begin
            prio_mask <= next_prio_mask;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# builds the register file testbench with Verilator and runs it
# the exit status of the simulation is the result of the run
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module prf_tb -o prf_sim

./obj_dir/prf_sim
